// ==== common/lsu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit core-side definitions
// access sizes, sequencing states, the execute-stage request and the
// access controls held while a response is outstanding
//////////////////////////////////////////////////////////////////////
package lsu_pkg;

  // word geometry
  localparam int unsigned LSU_WORD_W   = 32;
  localparam int unsigned LSU_OFFSET_W = 2;
  localparam int unsigned LSU_BYTES    = 4;

  // access size as encoded by the decoder
  // both byte codes behave the same
  typedef enum logic [1:0] {
    SIZE_WORD     = 2'b00,
    SIZE_HALF     = 2'b01,
    SIZE_BYTE     = 2'b10,
    SIZE_BYTE_ALT = 2'b11
  } lsu_size_e;

  // bus sequencing states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_state_e;

  // access from the execute stage, addr is the raw adder result
  typedef struct packed {
    logic                  we;
    lsu_size_e             size;
    logic                  sign_ext;
    logic [LSU_WORD_W-1:0] wdata;
    logic [LSU_WORD_W-1:0] addr;
  } lsu_req_t;

  // controls captured on a grant, used when the response returns
  typedef struct packed {
    logic [LSU_OFFSET_W-1:0] offset;
    lsu_size_e               size;
    logic                    sign_ext;
    logic                    we;
  } lsu_ctrl_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// data memory bus definitions
// word-aligned request payload with byte enables, and the response
//////////////////////////////////////////////////////////////////////
package mem_bus_pkg;

  // bus geometry
  localparam int unsigned BUS_ADDR_W = 32;
  localparam int unsigned BUS_DATA_W = 32;
  localparam int unsigned BUS_BE_W   = 4;

  // request payload, valid while data_req is high
  // addr always word aligned, be selects the written lanes
  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic                  we;
    logic [BUS_BE_W-1:0]   be;
    logic [BUS_DATA_W-1:0] wdata;
  } mem_req_t;

  // response, one rvalid per granted request, in order
  // err flags a failed access, rdata only meaningful for loads
  typedef struct packed {
    logic                  rvalid;
    logic                  err;
    logic [BUS_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== files.f ====
common/lsu_pkg.sv
common/mem_bus_pkg.sv
lsu/lsu_ctrl_fsm.sv
lsu/lsu_store_align.sv
lsu/lsu_load_align.sv
rtl/load_store_unit.sv
tests/tb_load_store_unit.sv

// ==== lsu/lsu_ctrl_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// load/store sequencing FSM
// issues one bus request, or two for a split access, and reports the
// response with the combined bus error of both halves
//////////////////////////////////////////////////////////////////////
module lsu_ctrl_fsm
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // core side
  input  logic     lsu_req_i,
  input  logic     lsu_we_i,
  input  logic     split_i,

  // bus handshake
  input  logic     data_gnt_i,
  input  mem_rsp_t rsp_i,
  output logic     data_req_o,

  // datapath control
  output logic     addr_incr_req_o,
  output logic     second_half_o,
  output logic     addr_update_o,
  output logic     ctrl_update_o,
  output logic     rdata_update_o,

  // status to the core
  output logic     lsu_req_done_o,
  output logic     lsu_resp_valid_o,
  output logic     lsu_rdata_valid_o,
  output logic     load_err_o,
  output logic     store_err_o,
  output logic     busy_o
);

  ls_state_e state_q, state_d;

  // high from the first grant of a split access until its second grant
  logic second_half_q, second_half_d;
  // bus error seen on the first half
  logic lsu_err_q, lsu_err_d;
  logic resp_err;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_half_d   = second_half_q;
    lsu_err_d       = lsu_err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update_o   = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update_o = 1'b1;
            second_half_d = split_i;
            state_d       = split_i ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d = split_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      // first half of a split access still waiting for its grant
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          second_half_d = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      // second half on the bus, first response outstanding
      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (rsp_i.rvalid) begin
          lsu_err_d      = rsp_i.err;
          rdata_update_o = ~lsu_we_i;
          // keep the failing first address for the core
          addr_update_o  = data_gnt_i & ~rsp_i.err;
          second_half_d  = ~data_gnt_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_half_d = 1'b0;
          state_d       = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      // single access, or second half once the first response is in
      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_half_q;
        if (data_gnt_i) begin
          // controls of a split access were taken on its first grant,
          // the second address carries no byte offset
          ctrl_update_o = ~second_half_q;
          addr_update_o = ~lsu_err_q;
          second_half_d = 1'b0;
          state_d       = IDLE;
        end
      end

      // both halves granted, first response still due
      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;
        if (rsp_i.rvalid) begin
          lsu_err_d      = rsp_i.err;
          addr_update_o  = ~rsp_i.err;
          rdata_update_o = ~lsu_we_i;
          state_d        = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      second_half_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_half_q <= second_half_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////

  assign second_half_o = second_half_q;
  assign busy_o        = (state_q != IDLE);

  // done once the last request is on its way and nothing else is due
  assign lsu_req_done_o = (lsu_req_i | busy_o) & (state_d == IDLE);

  // the final response always returns in IDLE
  assign resp_err          = lsu_err_q | rsp_i.err;
  assign lsu_resp_valid_o  = rsp_i.rvalid & (state_q == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~lsu_we_i;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~lsu_we_i;
  assign store_err_o       = lsu_resp_valid_o & resp_err & lsu_we_i;

  // state register only ever holds a legal encoding
  state_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT,
                    WAIT_RVALID_MIS_GNTS_DONE});

  // a new access is only picked up from a known request strobe
  req_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> !$isunknown(lsu_req_i));

endmodule

// ==== lsu/lsu_load_align.sv ====
//////////////////////////////////////////////////////////////////////
// load-side alignment
// captures the access controls, keeps the first half of a split load
// and realigns and extends the returned data
//////////////////////////////////////////////////////////////////////
module lsu_load_align
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_req_t              req_i,
  input  logic                  ctrl_update_i,
  input  logic                  rdata_update_i,
  input  mem_rsp_t              rsp_i,
  output lsu_ctrl_t             ctrl_o,
  output logic [LSU_WORD_W-1:0] lsu_rdata_o
);

  lsu_ctrl_t ctrl_q, ctrl_d;

  // upper three bytes of the first response
  logic [LSU_WORD_W-1:8] rdata_q;

  logic [LSU_WORD_W-1:0] rdata_w;
  logic [15:0]           half;
  logic [7:0]            byte_v;
  logic [LSU_WORD_W-1:0] rdata_h_ext;
  logic [LSU_WORD_W-1:0] rdata_b_ext;

  //////////////////////////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////////////////////////

  assign ctrl_d.offset   = req_i.addr[LSU_OFFSET_W-1:0];
  assign ctrl_d.size     = req_i.size;
  assign ctrl_d.sign_ext = req_i.sign_ext;
  assign ctrl_d.we       = req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '{offset: '0, size: SIZE_WORD, sign_ext: 1'b0, we: 1'b0};
    end else if (ctrl_update_i) begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= rsp_i.rdata[LSU_WORD_W-1:8];
    end
  end

  assign ctrl_o = ctrl_q;

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // word: stored high bytes of the first word, low bytes of the second
  always_comb begin
    unique case (ctrl_q.offset)
      2'd1:    rdata_w = {rsp_i.rdata[7:0], rdata_q[31:8]};
      2'd2:    rdata_w = {rsp_i.rdata[15:0], rdata_q[31:16]};
      2'd3:    rdata_w = {rsp_i.rdata[23:0], rdata_q[31:24]};
      default: rdata_w = rsp_i.rdata;
    endcase
  end

  // half word, offset 3 joins across the word boundary
  always_comb begin
    unique case (ctrl_q.offset)
      2'd1:    half = rsp_i.rdata[23:8];
      2'd2:    half = rsp_i.rdata[31:16];
      2'd3:    half = {rsp_i.rdata[7:0], rdata_q[31:24]};
      default: half = rsp_i.rdata[15:0];
    endcase
  end

  // byte never splits
  assign byte_v = rsp_i.rdata[{ctrl_q.offset, 3'b000} +: 8];

  // zero or sign extension from the top bit
  assign rdata_h_ext = ctrl_q.sign_ext ? {{16{half[15]}}, half} : {16'h0000, half};
  assign rdata_b_ext = ctrl_q.sign_ext ? {{24{byte_v[7]}}, byte_v} : {24'h00_0000, byte_v};

  always_comb begin
    unique case (ctrl_q.size)
      SIZE_WORD: lsu_rdata_o = rdata_w;
      SIZE_HALF: lsu_rdata_o = rdata_h_ext;
      default:   lsu_rdata_o = rdata_b_ext;
    endcase
  end

  // captured controls steer the FSM error split, so they must stay known
  ctrl_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(ctrl_o));

endmodule

// ==== lsu/lsu_store_align.sv ====
//////////////////////////////////////////////////////////////////////
// store-side alignment
// split detection, byte enables, store data rotation, word-aligned bus
// address and the last-address register
//////////////////////////////////////////////////////////////////////
module lsu_store_align
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_req_t              req_i,
  input  logic                  second_half_i,
  input  logic                  addr_incr_i,
  input  logic                  addr_update_i,
  output logic                  split_o,
  output mem_req_t              bus_req_o,
  output logic [LSU_WORD_W-1:0] addr_last_o
);

  logic [LSU_WORD_W-1:0]   addr_last_q, addr_last_d;
  logic [LSU_WORD_W-1:0]   addr_aligned;
  logic [LSU_OFFSET_W-1:0] offset;
  logic [LSU_BYTES-1:0]    be;
  logic [BUS_DATA_W-1:0]   wdata;

  // the second word address comes in aligned, so the byte offset of a
  // split access is taken from the first address held in addr_last
  assign offset = addr_incr_i ? addr_last_q[LSU_OFFSET_W-1:0]
                              : req_i.addr[LSU_OFFSET_W-1:0];

  assign addr_aligned = {req_i.addr[LSU_WORD_W-1:LSU_OFFSET_W], {LSU_OFFSET_W{1'b0}}};

  // misaligned word, or half word crossing into the next word
  assign split_o = ((req_i.size == SIZE_WORD) && (offset != '0)) ||
                   ((req_i.size == SIZE_HALF) && (offset == 2'd3));

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.size)
      SIZE_WORD: begin
        // first half covers offset and up, second half the rest
        if (!second_half_i) begin
          be = 4'b1111 << offset;
        end else begin
          be = 4'b1111 >> (3'd4 - {1'b0, offset});
        end
      end
      SIZE_HALF: begin
        // only offset 3 spills one byte into the next word
        be = second_half_i ? 4'b0001 : (4'b0011 << offset);
      end
      default: begin
        be = 4'b0001 << offset;
      end
    endcase
  end

  // rotate store data left by the byte offset so each byte lands in
  // its lane, the same rotation serves both halves
  always_comb begin
    unique case (offset)
      2'd1:    wdata = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'd2:    wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'd3:    wdata = {req_i.wdata[7:0], req_i.wdata[31:8]};
      default: wdata = req_i.wdata;
    endcase
  end

  assign bus_req_o.addr  = addr_aligned;
  assign bus_req_o.we    = req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

  //////////////////////////////////////////////////////////////////////
  // last address
  //////////////////////////////////////////////////////////////////////

  // full address for a first or single access, aligned word otherwise
  assign addr_last_d = addr_incr_i ? addr_aligned : req_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update_i) begin
      addr_last_q <= addr_last_d;
    end
  end

  assign addr_last_o = addr_last_q;

  // the second half goes to the word after the first, word aligned
  second_addr_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    second_half_i |-> (bus_req_o.addr[LSU_OFFSET_W-1:0] == '0) &&
      (bus_req_o.addr[LSU_WORD_W-1:LSU_OFFSET_W] ==
       addr_last_q[LSU_WORD_W-1:LSU_OFFSET_W] + 1'b1));

endmodule

// ==== rtl/load_store_unit.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit top level
// connects the sequencing FSM and both alignment blocks to the core
// and to the data memory bus
//////////////////////////////////////////////////////////////////////
module load_store_unit
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // execute stage
  input  logic                  lsu_req_i,
  input  lsu_req_t              lsu_req_i_s,
  output logic [LSU_WORD_W-1:0] lsu_rdata_o,
  output logic                  lsu_rdata_valid_o,
  output logic                  lsu_resp_valid_o,
  output logic                  lsu_req_done_o,
  output logic                  addr_incr_req_o,
  output logic [LSU_WORD_W-1:0] addr_last_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output logic                  busy_o,

  // data memory bus
  output logic                  data_req_o,
  output mem_req_t              data_o,
  input  logic                  data_gnt_i,
  input  mem_rsp_t              data_rsp_i
);

  // FSM to datapath strobes
  logic      second_half;
  logic      addr_update;
  logic      ctrl_update;
  logic      rdata_update;
  logic      split;
  lsu_ctrl_t ctrl;

  lsu_ctrl_fsm i_lsu_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (ctrl.we),
    .split_i           (split),
    .data_gnt_i        (data_gnt_i),
    .rsp_i             (data_rsp_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_half_o     (second_half),
    .addr_update_o     (addr_update),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  // request payload and last address
  lsu_store_align i_lsu_store_align (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (lsu_req_i_s),
    .second_half_i (second_half),
    .addr_incr_i   (addr_incr_req_o),
    .addr_update_i (addr_update),
    .split_o       (split),
    .bus_req_o     (data_o),
    .addr_last_o   (addr_last_o)
  );

  // response data
  lsu_load_align i_lsu_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (lsu_req_i_s),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .rsp_i          (data_rsp_i),
    .ctrl_o         (ctrl),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

// ==== tests/tb_load_store_unit.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit testbench
// table-driven accesses against a small memory responder with random
// grant delays and error injection
//////////////////////////////////////////////////////////////////////
module tb_load_store_unit
  import lsu_pkg::*;
  import mem_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MEM_WORDS = 16;
  localparam int unsigned ACC_LIMIT = 60;
  localparam logic [31:0] NO_ERR    = 32'hffff_ffff;

  typedef struct {
    string       name;
    logic        we;
    lsu_size_e   size;
    logic        sign_ext;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] err_addr;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [31:0] exp_last;
  } vec_t;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_req_i;
  lsu_req_t    lsu_req_s;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rdata_valid_o;
  logic        lsu_resp_valid_o;
  logic        lsu_req_done_o;
  logic        addr_incr_req_o;
  logic [31:0] addr_last_o;
  logic        load_err_o;
  logic        store_err_o;
  logic        busy_o;
  logic        data_req_o;
  mem_req_t    data_o;
  logic        data_gnt_i;
  mem_rsp_t    data_rsp_i;

  // core-side request fields, addr comes from the address generator
  logic        req_we;
  lsu_size_e   req_size;
  logic        req_sext;
  logic [31:0] req_wdata;
  logic [31:0] tbl_addr;
  logic [31:0] req_addr;
  logic [31:0] err_word;

  logic [31:0] mem [0:MEM_WORDS-1];
  integer      seed;
  int unsigned wait_cnt;
  logic [31:0] gnt_addr_q[$];
  logic        gnt_incr_q[$];
  vec_t        table_q[$];
  int          err_cnt;
  bit          timed_out;

  load_store_unit i_load_store_unit (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_req_i_s       (lsu_req_s),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .data_req_o        (data_req_o),
    .data_o            (data_o),
    .data_gnt_i        (data_gnt_i),
    .data_rsp_i        (data_rsp_i)
  );

  always #5 clk_i = ~clk_i;

  // next word while the second half is on the bus
  assign req_addr  = addr_incr_req_o ? {addr_last_o[31:2], 2'b00} + 32'd4 : tbl_addr;
  assign lsu_req_s = '{we: req_we, size: req_size, sign_ext: req_sext,
                       wdata: req_wdata, addr: req_addr};

  // byte pattern, low two address bits on top so some bytes are negative
  function automatic logic [7:0] pattern_byte(int unsigned b);
    logic [5:0] a;
    a = b[5:0];
    return {a[1:0], a};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [3:0] idx;
    logic       hit;
    int         draw;
    if (!rst_ni) begin
      data_gnt_i <= 1'b0;
      data_rsp_i <= '0;
      wait_cnt   <= 0;
    end else if (data_req_o && data_gnt_i) begin
      idx  = data_o.addr[5:2];
      hit  = ({data_o.addr[31:2], 2'b00} == err_word);
      // response one cycle after the grant, old contents on the bus
      data_rsp_i <= '{rvalid: 1'b1, err: hit, rdata: mem[idx]};
      if (data_o.we && !hit) begin
        for (int l = 0; l < 4; l++) begin
          if (data_o.be[l]) mem[idx][8*l +: 8] = data_o.wdata[8*l +: 8];
        end
      end
      gnt_addr_q.push_back(data_o.addr);
      gnt_incr_q.push_back(addr_incr_req_o);
      draw = $unsigned($random(seed)) % 3;
      wait_cnt   <= draw;
      data_gnt_i <= (draw == 0);
    end else begin
      data_rsp_i <= '0;
      if (data_req_o && !data_gnt_i) begin
        if (wait_cnt <= 1) data_gnt_i <= 1'b1;
        else wait_cnt <= wait_cnt - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_vec(string name, logic we, lsu_size_e size, logic sext, logic [31:0] addr,
                         logic [31:0] wdata, logic [31:0] err_addr, logic [31:0] exp_rdata,
                         logic exp_err, logic [31:0] exp_last);
    vec_t v;
    v = '{name, we, size, sext, addr, wdata, err_addr, exp_rdata, exp_err, exp_last};
    table_q.push_back(v);
  endtask

  task automatic run_access(vec_t v);
    int          cycles;
    int          done_cnt;
    bit          got_resp;
    bit          split;
    logic [31:0] rdata;
    logic        rvalid;
    logic        lerr;
    logic        serr;
    logic [31:0] last;
    cycles   = 0;
    done_cnt = 0;
    got_resp = 0;
    split    = ((v.size == SIZE_WORD) && (v.addr[1:0] != 2'd0)) ||
               ((v.size == SIZE_HALF) && (v.addr[1:0] == 2'd3));
    gnt_addr_q.delete();
    gnt_incr_q.delete();
    @(posedge clk_i);
    lsu_req_i <= 1'b1;
    req_we    <= v.we;
    req_size  <= v.size;
    req_sext  <= v.sign_ext;
    req_wdata <= v.wdata;
    tbl_addr  <= v.addr;
    err_word  <= v.err_addr;
    while (!got_resp && cycles < ACC_LIMIT) begin
      @(negedge clk_i);
      if (lsu_req_done_o) done_cnt++;
      if (lsu_resp_valid_o) begin
        got_resp = 1;
        rdata    = lsu_rdata_o;
        rvalid   = lsu_rdata_valid_o;
        lerr     = load_err_o;
        serr     = store_err_o;
        last     = addr_last_o;
      end
      @(posedge clk_i);
      if (done_cnt > 0) lsu_req_i <= 1'b0;
      cycles++;
    end
    if (!got_resp) begin
      $display("Timeout in %s: no response from the load/store unit", v.name);
      err_cnt++;
      timed_out = 1;
    end else begin
      // unit back in idle in the cycle after its response
      @(negedge clk_i);
      compare_value(v.name, "busy", 0, busy_o);
      compare_value(v.name, "done pulses", 1, done_cnt);
      compare_value(v.name, "bus requests", split ? 2 : 1, gnt_addr_q.size());
      if (gnt_addr_q.size() > 0) begin
        compare_value(v.name, "first addr", {v.addr[31:2], 2'b00}, gnt_addr_q[0]);
        compare_value(v.name, "first incr", 0, gnt_incr_q[0]);
      end
      if (split && gnt_addr_q.size() == 2) begin
        compare_value(v.name, "second addr", {v.addr[31:2], 2'b00} + 4, gnt_addr_q[1]);
        compare_value(v.name, "second incr", 1, gnt_incr_q[1]);
      end
      compare_value(v.name, "load_err", !v.we && v.exp_err, lerr);
      compare_value(v.name, "store_err", v.we && v.exp_err, serr);
      compare_value(v.name, "rdata_valid", !v.we && !v.exp_err, rvalid);
      if (!v.we && !v.exp_err) compare_value(v.name, "rdata", v.exp_rdata, rdata);
      compare_value(v.name, "addr_last", v.exp_last, last);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    lsu_req_i  = 1'b0;
    req_we     = 1'b0;
    req_size   = SIZE_WORD;
    req_sext   = 1'b0;
    req_wdata  = '0;
    tbl_addr   = '0;
    err_word   = NO_ERR;
    data_gnt_i = 1'b0;
    data_rsp_i = '0;
    seed       = 32'hd592_e225;
    err_cnt    = 0;
    timed_out  = 0;
    for (int b = 0; b < 4 * MEM_WORDS; b++) mem[b / 4][8 * (b % 4) +: 8] = pattern_byte(b);

    // aligned words, bytes and halves at every offset
    add_vec("sw_00", 1, SIZE_WORD, 0, 32'h00, 32'h1234_5678, NO_ERR, 0, 0, 32'h00);
    add_vec("lw_00", 0, SIZE_WORD, 0, 32'h00, 0, NO_ERR, 32'h1234_5678, 0, 32'h00);
    add_vec("sw_04", 1, SIZE_WORD, 0, 32'h04, 32'h8765_4321, NO_ERR, 0, 0, 32'h04);
    add_vec("lw_04", 0, SIZE_WORD, 0, 32'h04, 0, NO_ERR, 32'h8765_4321, 0, 32'h04);
    add_vec("lb_08_s", 0, SIZE_BYTE, 1, 32'h08, 0, NO_ERR, 32'h0000_0008, 0, 32'h08);
    add_vec("lb_09_z", 0, SIZE_BYTE, 0, 32'h09, 0, NO_ERR, 32'h0000_0049, 0, 32'h09);
    add_vec("lb_0a_s", 0, SIZE_BYTE_ALT, 1, 32'h0a, 0, NO_ERR, 32'hffff_ff8a, 0, 32'h0a);
    add_vec("lb_0b_z", 0, SIZE_BYTE, 0, 32'h0b, 0, NO_ERR, 32'h0000_00cb, 0, 32'h0b);
    add_vec("lh_08_s", 0, SIZE_HALF, 1, 32'h08, 0, NO_ERR, 32'h0000_4908, 0, 32'h08);
    add_vec("lh_09_s", 0, SIZE_HALF, 1, 32'h09, 0, NO_ERR, 32'hffff_8a49, 0, 32'h09);
    add_vec("lh_0a_z", 0, SIZE_HALF, 0, 32'h0a, 0, NO_ERR, 32'h0000_cb8a, 0, 32'h0a);
    add_vec("lh_0b_s", 0, SIZE_HALF, 1, 32'h0b, 0, NO_ERR, 32'h0000_0ccb, 0, 32'h0c);
    add_vec("sb_11", 1, SIZE_BYTE_ALT, 0, 32'h11, 32'h0000_00a5, NO_ERR, 0, 0, 32'h11);
    add_vec("sh_12", 1, SIZE_HALF, 0, 32'h12, 32'h0000_beef, NO_ERR, 0, 0, 32'h12);
    add_vec("lw_10", 0, SIZE_WORD, 0, 32'h10, 0, NO_ERR, 32'hbeef_a510, 0, 32'h10);
    // split accesses
    add_vec("lw_21", 0, SIZE_WORD, 0, 32'h21, 0, NO_ERR, 32'h24e3_a261, 0, 32'h24);
    add_vec("lw_22", 0, SIZE_WORD, 0, 32'h22, 0, NO_ERR, 32'h6524_e3a2, 0, 32'h24);
    add_vec("lw_23", 0, SIZE_WORD, 0, 32'h23, 0, NO_ERR, 32'ha665_24e3, 0, 32'h24);
    add_vec("sw_29", 1, SIZE_WORD, 0, 32'h29, 32'hddcc_bbaa, NO_ERR, 0, 0, 32'h2c);
    add_vec("lw_28", 0, SIZE_WORD, 0, 32'h28, 0, NO_ERR, 32'hccbb_aa28, 0, 32'h28);
    add_vec("lw_2c", 0, SIZE_WORD, 0, 32'h2c, 0, NO_ERR, 32'hefae_6ddd, 0, 32'h2c);
    add_vec("sh_1f", 1, SIZE_HALF, 0, 32'h1f, 32'h0000_7e5a, NO_ERR, 0, 0, 32'h20);
    add_vec("lh_1f_s", 0, SIZE_HALF, 1, 32'h1f, 0, NO_ERR, 32'h0000_7e5a, 0, 32'h20);
    add_vec("lw_1c", 0, SIZE_WORD, 0, 32'h1c, 0, NO_ERR, 32'h5a9e_5d1c, 0, 32'h1c);
    add_vec("lw_20", 0, SIZE_WORD, 0, 32'h20, 0, NO_ERR, 32'he3a2_617e, 0, 32'h20);
    add_vec("sw_17", 1, SIZE_WORD, 0, 32'h17, 32'h4433_2211, NO_ERR, 0, 0, 32'h18);
    add_vec("lw_14", 0, SIZE_WORD, 0, 32'h14, 0, NO_ERR, 32'h1196_5514, 0, 32'h14);
    add_vec("lw_18", 0, SIZE_WORD, 0, 32'h18, 0, NO_ERR, 32'hdb44_3322, 0, 32'h18);
    // bus errors on single, first and second halves
    add_vec("lw_30_err", 0, SIZE_WORD, 0, 32'h30, 0, 32'h30, 0, 1, 32'h30);
    add_vec("sw_34_err", 1, SIZE_WORD, 0, 32'h34, 32'hffff_ffff, 32'h34, 0, 1, 32'h34);
    add_vec("lw_31_err1", 0, SIZE_WORD, 0, 32'h31, 0, 32'h30, 0, 1, 32'h31);
    add_vec("lw_33_err2", 0, SIZE_WORD, 0, 32'h33, 0, 32'h34, 0, 1, 32'h34);
    add_vec("sw_36_err2", 1, SIZE_WORD, 0, 32'h36, 32'h1122_3344, 32'h38, 0, 1, 32'h38);
    add_vec("lw_34", 0, SIZE_WORD, 0, 32'h34, 0, NO_ERR, 32'h3344_7534, 0, 32'h34);
    add_vec("sh_3b_err1", 1, SIZE_HALF, 0, 32'h3b, 32'h0000_9988, 32'h38, 0, 1, 32'h3b);
    add_vec("lw_3c", 0, SIZE_WORD, 0, 32'h3c, 0, NO_ERR, 32'hffbe_7d99, 0, 32'h3c);

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare_value("reset", "busy", 0, busy_o);
    compare_value("reset", "data_req", 0, data_req_o);
    compare_value("reset", "resp_valid", 0, lsu_resp_valid_o);
    compare_value("reset", "req_done", 0, lsu_req_done_o);
    compare_value("reset", "addr_incr", 0, addr_incr_req_o);
    compare_value("reset", "rdata_valid", 0, lsu_rdata_valid_o);
    compare_value("reset", "load_err", 0, load_err_o);
    compare_value("reset", "store_err", 0, store_err_o);

    for (int i = 0; i < table_q.size() && !timed_out; i++) begin
      run_access(table_q[i]);
    end

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
